// File: design/exec_pkg.sv
package exec_pkg;

    localparam int XLEN        = 32;
    localparam int ROB_TAG_LEN = 5;

    typedef logic [XLEN-1:0]        xlen_t;     // Register values, immediates, PCs
    typedef logic [ROB_TAG_LEN-1:0] rob_tag_t;  // ROB entry tag

    // Execute function codes shared by the ALU and branch issue ports
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        BTU_BEQ,
        BTU_BNE,
        BTU_BLT,
        BTU_BGE,
        BTU_BLTU,
        BTU_BGEU,
        BTU_JAL,
        BTU_JALR
    } alu_func_t;

    // Instruction as it leaves a reservation station
    typedef struct packed {
        alu_func_t func;
        xlen_t     pc;
        xlen_t     imm;
        xlen_t     value_src1;
        xlen_t     value_src2;
        rob_tag_t  insn_tag;    // ROB entry of the instruction
        rob_tag_t  tag_dest;    // Tag broadcast with the result
    } inst_rs_t;

endpackage

// File: design/fu_result_if.sv
`timescale 1ns/1ps

interface fu_result_if import exec_pkg::*; ();

    logic     done;         // One-cycle completion strobe
    rob_tag_t result_tag;
    rob_tag_t insn_tag;
    xlen_t    wb_data;

    modport producer (
        output done,
        output result_tag,
        output insn_tag,
        output wb_data
    );

    modport consumer (
        input  done,
        input  result_tag,
        input  insn_tag,
        input  wb_data
    );

endinterface

// File: design/issue_regs.sv
`timescale 1ns/1ps

module issue_regs import exec_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     alu_valid,
    input  inst_rs_t alu_insn,
    input  logic     br_valid,
    input  inst_rs_t br_insn,
    output logic     alu_en,
    output inst_rs_t alu_q,
    output logic     br_en,
    output inst_rs_t br_q
);

    logic alu_accept;
    logic br_accept;

    assign alu_accept = alu_valid & ~stall;
    assign br_accept  = br_valid & ~stall;

    // Bubbles go in while stalled, the issuer retries
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_en <= 1'b0;
            br_en  <= 1'b0;
        end else begin
            alu_en <= alu_accept;
            br_en  <= br_accept;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_accept) begin
            alu_q <= alu_insn;
        end
        if (br_accept) begin
            br_q <= br_insn;
        end
    end

endmodule

// File: design/int_alu.sv
`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
    input  inst_rs_t             insn,
    input  logic                 en,
    fu_result_if.producer        fu
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;

    assign op_a  = insn.value_src1;
    assign op_b  = insn.value_src2;
    assign shamt = op_b[4:0];   // RV32I uses the low 5 bits

    always_comb begin
        fu.wb_data = '0;
        unique case (insn.func)
            ALU_ADD:  fu.wb_data = op_a + op_b;
            ALU_SUB:  fu.wb_data = op_a - op_b;
            ALU_AND:  fu.wb_data = op_a & op_b;
            ALU_OR:   fu.wb_data = op_a | op_b;
            ALU_XOR:  fu.wb_data = op_a ^ op_b;
            ALU_SLL:  fu.wb_data = op_a << shamt;
            ALU_SRL:  fu.wb_data = op_a >> shamt;
            ALU_SRA:  fu.wb_data = xlen_t'($signed(op_a) >>> shamt);
            ALU_SLT:  fu.wb_data = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: fu.wb_data = xlen_t'(op_a < op_b);
            default:  fu.wb_data = '0;  // Branch codes never reach this port
        endcase
    end

    assign fu.result_tag = insn.tag_dest;
    assign fu.insn_tag   = insn.insn_tag;
    assign fu.done       = en;

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  inst_rs_t             insn,
    input  logic                 en,
    fu_result_if.producer        fu,
    output logic                 cond,       // Taken, so a mispredict
    output xlen_t                target_pc
);

    xlen_t pc;
    xlen_t imm;
    xlen_t rs1;
    xlen_t rs2;
    logic  is_cond_br;

    assign pc  = insn.pc;
    assign imm = insn.imm;
    assign rs1 = insn.value_src1;
    assign rs2 = insn.value_src2;

    assign is_cond_br = (insn.func == BTU_BEQ) || (insn.func == BTU_BNE) ||
                        (insn.func == BTU_BLT) || (insn.func == BTU_BGE) ||
                        (insn.func == BTU_BLTU) || (insn.func == BTU_BGEU);

    always_comb begin
        cond = 1'b0;
        unique case (insn.func)
            BTU_BEQ:  cond = (rs1 == rs2);
            BTU_BNE:  cond = (rs1 != rs2);
            BTU_BLT:  cond = ($signed(rs1) < $signed(rs2));
            BTU_BGE:  cond = ($signed(rs1) >= $signed(rs2));
            BTU_BLTU: cond = (rs1 < rs2);
            BTU_BGEU: cond = (rs1 >= rs2);
            BTU_JAL:  cond = 1'b1;
            BTU_JALR: cond = 1'b1;
            default:  cond = 1'b0;
        endcase
    end

    // Target and link value
    always_comb begin
        fu.wb_data = '0;
        target_pc  = pc + 32'd4;
        if (is_cond_br) begin
            target_pc = pc + imm;
        end else if (insn.func == BTU_JAL) begin
            target_pc  = pc + imm;
            fu.wb_data = pc + 32'd4;
        end else if (insn.func == BTU_JALR) begin
            target_pc  = rs1 + imm;     // Register based jump
            fu.wb_data = pc + 32'd4;
        end
    end

    assign fu.result_tag = insn.tag_dest;
    assign fu.insn_tag   = insn.insn_tag;
    assign fu.done       = en;

endmodule

// File: design/complete_arbiter.sv
`timescale 1ns/1ps

module complete_arbiter import exec_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    fu_result_if.consumer        alu,
    fu_result_if.consumer        br,
    input  logic                 br_cond,
    input  xlen_t                br_target,
    output logic                 stall,
    output logic                 cdb_valid,
    output rob_tag_t             cdb_tag,
    output rob_tag_t             cdb_insn_tag,
    output xlen_t                cdb_value,
    output logic                 redirect_valid,
    output xlen_t                redirect_pc
);

    logic     hold_valid;
    rob_tag_t hold_tag;
    rob_tag_t hold_insn_tag;
    xlen_t    hold_data;

    logic     alu_loses;
    rob_tag_t sel_tag;
    rob_tag_t sel_insn_tag;
    xlen_t    sel_value;

    // ALU result parks in the hold if anything outranks it
    assign alu_loses = alu.done & (hold_valid | br.done);

    // Blocks issue during the collision cycle so the hold drains into an idle slot
    assign stall = alu.done & br.done & ~hold_valid;

    always_comb begin
        if (hold_valid) begin
            sel_tag      = hold_tag;
            sel_insn_tag = hold_insn_tag;
            sel_value    = hold_data;
        end else if (br.done) begin
            sel_tag      = br.result_tag;
            sel_insn_tag = br.insn_tag;
            sel_value    = br.wb_data;
        end else begin
            sel_tag      = alu.result_tag;
            sel_insn_tag = alu.insn_tag;
            sel_value    = alu.wb_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cdb_valid      <= 1'b0;
            redirect_valid <= 1'b0;
            hold_valid     <= 1'b0;
        end else begin
            cdb_valid      <= hold_valid | br.done | alu.done;
            redirect_valid <= ~hold_valid & br.done & br_cond;
            hold_valid     <= alu_loses;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag      <= sel_tag;
        cdb_insn_tag <= sel_insn_tag;
        cdb_value    <= sel_value;
        redirect_pc  <= br_target;
        if (alu_loses) begin
            hold_tag      <= alu.result_tag;
            hold_insn_tag <= alu.insn_tag;
            hold_data     <= alu.wb_data;
        end
    end

    // Stall upstream must keep the ALU idle while its last result waits
    a_no_alu_into_full_hold: assert property (@(posedge clock) disable iff (!rst_n)
        hold_valid |-> !alu.done);

    a_redirect_on_cdb: assert property (@(posedge clock) disable iff (!rst_n)
        redirect_valid |-> cdb_valid);

    a_hold_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        hold_valid |=> !hold_valid);

endmodule

// File: design/exec_unit_top.sv
`timescale 1ns/1ps

module exec_unit_top import exec_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      alu_valid,
    input  alu_func_t alu_func,
    input  xlen_t     alu_src1,
    input  xlen_t     alu_src2,
    input  xlen_t     alu_imm,
    input  xlen_t     alu_pc,
    input  rob_tag_t  alu_tag_dest,
    input  rob_tag_t  alu_insn_tag,
    input  logic      br_valid,
    input  alu_func_t br_func,
    input  xlen_t     br_pc,
    input  xlen_t     br_imm,
    input  xlen_t     br_src1,
    input  xlen_t     br_src2,
    input  rob_tag_t  br_tag_dest,
    input  rob_tag_t  br_insn_tag,
    output logic      stall,
    output logic      cdb_valid,
    output rob_tag_t  cdb_tag,
    output rob_tag_t  cdb_insn_tag,
    output xlen_t     cdb_value,
    output logic      redirect_valid,
    output xlen_t     redirect_pc
);

    inst_rs_t alu_insn;
    inst_rs_t br_insn;
    inst_rs_t alu_q;
    inst_rs_t br_q;
    logic     alu_en;
    logic     br_en;
    logic     br_cond;
    xlen_t    br_target;

    fu_result_if alu_res ();
    fu_result_if br_res ();

    assign alu_insn = '{func: alu_func, pc: alu_pc, imm: alu_imm, value_src1: alu_src1,
                        value_src2: alu_src2, insn_tag: alu_insn_tag, tag_dest: alu_tag_dest};
    assign br_insn  = '{func: br_func, pc: br_pc, imm: br_imm, value_src1: br_src1,
                        value_src2: br_src2, insn_tag: br_insn_tag, tag_dest: br_tag_dest};

    issue_regs i_issue_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .stall     (stall),
        .alu_valid (alu_valid),
        .alu_insn  (alu_insn),
        .br_valid  (br_valid),
        .br_insn   (br_insn),
        .alu_en    (alu_en),
        .alu_q     (alu_q),
        .br_en     (br_en),
        .br_q      (br_q)
    );

    int_alu i_int_alu (
        .insn (alu_q),
        .en   (alu_en),
        .fu   (alu_res.producer)
    );

    branch_unit i_branch_unit (
        .insn      (br_q),
        .en        (br_en),
        .fu        (br_res.producer),
        .cond      (br_cond),
        .target_pc (br_target)
    );

    complete_arbiter i_complete_arbiter (
        .clock          (clock),
        .rst_n          (rst_n),
        .alu            (alu_res.consumer),
        .br             (br_res.consumer),
        .br_cond        (br_cond),
        .br_target      (br_target),
        .stall          (stall),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_insn_tag   (cdb_insn_tag),
        .cdb_value      (cdb_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: bench/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit import exec_pkg::*; ();

    localparam int NUM_ISSUES = 166;
    localparam int CYCLE_LIMIT = NUM_ISSUES * 4 + 100;

    logic clock, rst_n, alu_valid, br_valid;
    inst_rs_t a_in, b_in;
    logic stall, cdb_valid, redirect_valid;
    rob_tag_t cdb_tag, cdb_insn_tag;
    xlen_t cdb_value, redirect_pc;

    logic [31:0] lfsr;
    rob_tag_t next_tag;
    int cyc = 0;
    int err = 0;
    int retries;
    xlen_t exp_value[32];
    xlen_t exp_target[32];
    rob_tag_t exp_insn[32];
    bit exp_redir[32];
    int acc_cyc[32];
    int exp_lat[32];
    int issued[32] = '{default: 0};
    int bcast[32] = '{default: 0};

    exec_unit_top i_exec_unit_top (
        .clock(clock), .rst_n(rst_n),
        .alu_valid(alu_valid), .alu_func(a_in.func), .alu_src1(a_in.value_src1),
        .alu_src2(a_in.value_src2), .alu_imm(a_in.imm), .alu_pc(a_in.pc),
        .alu_tag_dest(a_in.tag_dest), .alu_insn_tag(a_in.insn_tag),
        .br_valid(br_valid), .br_func(b_in.func), .br_pc(b_in.pc), .br_imm(b_in.imm),
        .br_src1(b_in.value_src1), .br_src2(b_in.value_src2),
        .br_tag_dest(b_in.tag_dest), .br_insn_tag(b_in.insn_tag),
        .stall(stall), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_insn_tag(cdb_insn_tag), .cdb_value(cdb_value),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cyc <= cyc + 1;
        if (cdb_valid) bcast[cdb_tag] <= bcast[cdb_tag] + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Run stopped at cycle %0d, results still outstanding", cyc);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic void count_failure(string msg);
        err++;
        $display("%s", msg);
    endfunction

    a_tag_outstanding: assert property (@(posedge clock)
            cdb_valid |-> issued[cdb_tag] > bcast[cdb_tag])
        else count_failure($sformatf("Broadcast of tag %h that was not outstanding",
            $sampled(cdb_tag)));
    a_value: assert property (@(posedge clock) cdb_valid |-> cdb_value == exp_value[cdb_tag])
        else count_failure($sformatf("FAIL cdb_value tag %h got %h exp %h", $sampled(cdb_tag),
            $sampled(cdb_value), exp_value[$sampled(cdb_tag)]));
    a_insn_tag: assert property (@(posedge clock)
            cdb_valid |-> cdb_insn_tag == exp_insn[cdb_tag])
        else count_failure($sformatf("FAIL cdb_insn_tag tag %h got %h exp %h",
            $sampled(cdb_tag), $sampled(cdb_insn_tag), exp_insn[$sampled(cdb_tag)]));
    a_redirect: assert property (@(posedge clock)
            cdb_valid |-> redirect_valid == exp_redir[cdb_tag])
        else count_failure($sformatf("FAIL redirect_valid tag %h got %h exp %h",
            $sampled(cdb_tag), $sampled(redirect_valid), exp_redir[$sampled(cdb_tag)]));
    a_target: assert property (@(posedge clock)
            redirect_valid |-> redirect_pc == exp_target[cdb_tag])
        else count_failure($sformatf("FAIL redirect_pc tag %h got %h exp %h",
            $sampled(cdb_tag), $sampled(redirect_pc), exp_target[$sampled(cdb_tag)]));
    a_latency: assert property (@(posedge clock)
            cdb_valid |-> cyc - acc_cyc[cdb_tag] == exp_lat[cdb_tag])
        else count_failure($sformatf("FAIL latency tag %h got %h exp %h", $sampled(cdb_tag),
            $sampled(cyc) - acc_cyc[$sampled(cdb_tag)], exp_lat[$sampled(cdb_tag)]));
    a_reset_quiet: assert property (@(posedge clock) (cyc >= 2 && !rst_n) || $rose(rst_n)
            |-> !cdb_valid && !redirect_valid && !stall)
        else count_failure("Outputs not idle during or right after reset");

    function automatic logic [31:0] get_bits(int n);
        logic [31:0] v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // Galois step
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlen_t expected_alu_value(inst_rs_t i);
        xlen_t a = i.value_src1;
        xlen_t b = i.value_src2;
        case (i.func)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SRA: return xlen_t'($signed(a) >>> b[4:0]);
            ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
            default: return {31'd0, a < b};
        endcase
    endfunction

    function automatic void resolve_branch(inst_rs_t i, output bit taken, output xlen_t tgt,
                                           output xlen_t link);
        xlen_t a = i.value_src1;
        xlen_t b = i.value_src2;
        case (i.func)
            BTU_BEQ: taken = (a == b);
            BTU_BNE: taken = (a != b);
            BTU_BLT: taken = ($signed(a) < $signed(b));
            BTU_BGE: taken = ($signed(a) >= $signed(b));
            BTU_BLTU: taken = (a < b);
            BTU_BGEU: taken = (a >= b);
            default: taken = 1'b1;  // JAL, JALR
        endcase
        tgt = (i.func == BTU_JALR) ? a + i.imm : i.pc + i.imm;
        link = (i.func == BTU_JAL || i.func == BTU_JALR) ? i.pc + 32'd4 : '0;
    endfunction

    task automatic record(inst_rs_t i, bit is_br, int lat);
        bit taken;
        xlen_t tgt, link;
        if (is_br) begin
            resolve_branch(i, taken, tgt, link);
            exp_value[i.tag_dest] = link;
            exp_redir[i.tag_dest] = taken;
            exp_target[i.tag_dest] = tgt;
        end else begin
            exp_value[i.tag_dest] = expected_alu_value(i);
            exp_redir[i.tag_dest] = 1'b0;
        end
        exp_insn[i.tag_dest] = i.insn_tag;
        acc_cyc[i.tag_dest] = cyc;
        exp_lat[i.tag_dest] = lat;
        issued[i.tag_dest]++;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // Called 1 ns after a rising edge; holds the issue until stall is low
    task automatic issue(bit do_alu, inst_rs_t a, bit do_br, inst_rs_t b);
        if (do_alu) begin
            a.tag_dest = next_tag;
            a.insn_tag = next_tag + 5'd13;  // ROB entry apart from the result tag
            next_tag += 5'd1;
        end
        if (do_br) begin
            b.tag_dest = next_tag;
            b.insn_tag = next_tag + 5'd13;
            next_tag += 5'd1;
        end
        a_in = a;
        b_in = b;
        alu_valid = do_alu;
        br_valid = do_br;
        retries = 0;
        while (stall) begin
            retries++;
            next_cycle();
        end
        if (do_alu) record(a, 1'b0, do_br ? 3 : 2);  // ALU loses to a same-cycle branch
        if (do_br) record(b, 1'b1, 2);
        next_cycle();
        alu_valid = 1'b0;
        br_valid = 1'b0;
    endtask

    function automatic inst_rs_t make(int f, xlen_t s1, xlen_t s2, xlen_t pc, xlen_t imm);
        inst_rs_t i;
        i = '0;
        i.func = alu_func_t'(5'(f));
        i.value_src1 = s1;
        i.value_src2 = s2;
        i.pc = pc;
        i.imm = imm;
        return i;
    endfunction

    function automatic inst_rs_t rand_insn(bit is_br);
        int f = is_br ? int'(BTU_BEQ) + int'(get_bits(3)) : int'(get_bits(4) % 10);
        return make(f, get_bits(32), get_bits(32), get_bits(30) << 2, get_bits(30) << 2);
    endfunction

    task automatic drain_and_report(string name, int e0);
        int open;
        do begin
            open = 0;
            next_cycle();
            for (int t = 0; t < 32; t++) open += issued[t] - bcast[t];
        end while (open != 0);
        repeat (2) @(posedge clock);
        #1;
        $display("%-24s checks failed: %0d", name, err - e0);
    endtask

    initial begin
        xlen_t ops[4] = '{32'h0, 32'hffff_fff0, 32'h8000_0000, 32'h7fff_ff1f};
        int e0;
        lfsr = 32'h5506_ce68;
        next_tag = '0;
        // Issues offered during reset must stay invisible
        rst_n = 1'b0;
        alu_valid = 1'b1;
        br_valid = 1'b1;
        a_in = make(int'(ALU_ADD), 32'h1, 32'h2, '0, '0);
        b_in = make(int'(BTU_JAL), '0, '0, 32'h100, 32'h40);
        repeat (8) @(posedge clock);
        #1 rst_n = 1'b1;
        alu_valid = 1'b0;
        br_valid = 1'b0;
        next_cycle();
        $display("%-24s checks failed: %0d", "reset", err);

        e0 = err;
        for (int f = 0; f < 10; f++)
            for (int k = 0; k < 4; k++)
                issue(1'b1, make(f, ops[k], ops[(k + 2) % 4], '0, '0), 1'b0, '0);
        for (int n = 0; n < 60; n++) begin
            issue(1'b1, rand_insn(1'b0), 1'b0, '0);
            if (get_bits(1)) begin
                next_cycle();
            end
        end
        drain_and_report("alu results", e0);

        e0 = err;
        for (int f = int'(BTU_BEQ); f <= int'(BTU_BGEU); f++)
            for (int k = 0; k < 5; k++)
                issue(1'b0, '0, 1'b1, make(f, ops[k % 4], (k == 4) ? ops[0] : ops[(k + 2) % 4],
                      32'h1000, 32'h40));
        drain_and_report("branch decisions", e0);

        e0 = err;
        for (int n = 0; n < 8; n++)
            issue(1'b0, '0, 1'b1, make(n < 4 ? int'(BTU_JAL) : int'(BTU_JALR),
                  get_bits(30) << 2, get_bits(32), get_bits(30) << 2, 32'h20));
        drain_and_report("jumps", e0);

        e0 = err;
        for (int n = 0; n < 6; n++) begin
            issue(1'b1, rand_insn(1'b0), 1'b1, rand_insn(1'b1));
            assert (stall) else count_failure($sformatf("FAIL stall got %h exp %h", stall, 1'b1));
            issue(1'b1, rand_insn(1'b0), 1'b0, '0);
            assert (retries > 0)
                else count_failure("Issue offered during stall was accepted without a retry");
        end
        drain_and_report("arbitration and stall", e0);

        e0 = err;
        for (int n = 0; n < 10; n++) begin
            issue(~n[0], rand_insn(1'b0), n[0], rand_insn(1'b1));
            repeat (3) @(posedge clock);
            #1;
        end
        drain_and_report("latency", e0);

        $display("Tests run: 6, checks failed: %0d", err);
        if (err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
design/exec_pkg.sv
design/fu_result_if.sv
design/issue_regs.sv
design/int_alu.sv
design/branch_unit.sv
design/complete_arbiter.sv
design/exec_unit_top.sv
bench/tb_exec_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exec_unit \
    -f tb.f -o sim_exec_unit > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_exec_unit > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
